//--- filelist.f
design/efuse_pkg.sv
design/efuse_array.sv
design/efuse_ctl.sv
design/efuse_top.sv
testbench/efuse_props.sv
testbench/efuse_tb.sv

//--- run.sh
#!/bin/sh
# Build the efuse testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module efuse_tb -o efuse_sim
out=$(./obj_dir/efuse_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
	exit 0
fi
exit 1

//--- testbench/efuse_tb.sv
// Testbench for the efuse block
// Clock, reset, four-phase command task and response check
// Directed tests against an array reference model
// Galois LFSR stimulus, watchdog and summary line

`timescale 1ns/1ps

module efuse_tb
	import efuse_pkg::*;
();

	localparam int read_lat    = 6;	// Same as the efuse_top default
	localparam int prog_cycles = 3;	// Same as the efuse_top default
	localparam int ack_limit   = read_lat + prog_cycles + 8;	// Cycles allowed for ack
	localparam int num_cmds    = 120;	// At least the commands issued below
	localparam int cmd_len     = read_lat + prog_cycles + 6;	// Longest exchange in cycles
	localparam int wd_cycles   = num_cmds * cmd_len + 200;

	logic       l1clk;
	logic       reset;
	logic       req;
	efuse_cmd_t cmd;
	logic       pwr_ok;
	logic       power_down;
	logic       ack;
	efuse_rsp_t rsp;

	logic [efuse_width-1:0] ref_mem [efuse_words];	// Expected fuse contents
	logic [31:0]            lfsr;	// Random source state
	string                  cur_test;
	int                     errors;
	int                     checks;
	int                     tests;
	int                     err_base;	// Error count when the test started

	efuse_top efuse_inst (
		.l1clk      (l1clk),
		.reset      (reset),
		.req        (req),
		.cmd        (cmd),
		.pwr_ok     (pwr_ok),
		.power_down (power_down),
		.ack        (ack),
		.rsp        (rsp)
	);

	// 100 ns clock
	initial begin
		l1clk = 1'b0;
		forever #50 l1clk = ~l1clk;
	end

	// Watchdog sized from the command count
	initial begin
		#(wd_cycles * 100);
		$display("Timeout: run did not finish within %0d cycles", wd_cycles);
		$display("Verification failed");
		$finish;
	end

	// ******************************
	// Helpers
	// ******************************
	function automatic efuse_cmd_t make_cmd(efuse_op_t op, word_addr_t a, bit_addr_t b);
		efuse_cmd_t c;
		c.op    = op;
		c.waddr = a;
		c.baddr = b;
		return c;
	endfunction

	function automatic efuse_rsp_t make_rsp(efuse_status_t st, logic [efuse_width-1:0] d);
		efuse_rsp_t r;
		r.status = st;
		r.data   = d;
		return r;
	endfunction

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_rsp(input efuse_rsp_t expected, input efuse_rsp_t actual);
		checks++;
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", cur_test, expected, actual);
			errors++;
		end
	endtask

	// Full four-phase exchange, entered and left 5 ns after a rising edge
	task automatic do_cmd(input efuse_cmd_t c, output efuse_rsp_t r);
		int n;
		cmd = c;
		req = 1'b1;
		n   = 0;
		do begin
			@(posedge l1clk);
			#5;
			n++;
		end while (!ack && n < ack_limit);
		if (!ack) begin
			$display("%s: no ack within %0d cycles of the request", cur_test, ack_limit);
			errors++;
		end
		r   = rsp;	// rsp is held while ack is high
		req = 1'b0;
		n   = 0;
		do begin
			@(posedge l1clk);
			#5;
			n++;
		end while (ack && n < ack_limit);
		if (ack) begin
			$display("%s: ack stayed high after req was dropped", cur_test);
			errors++;
		end
		cmd = '0;
	endtask

	task automatic read_and_check(input word_addr_t a);
		efuse_rsp_t r;
		do_cmd(make_cmd(op_read, a, 5'd0), r);
		check_rsp(make_rsp(st_ok, ref_mem[a]), r);
	endtask

	// Model is updated only when the program is expected to go through
	task automatic program_bit(input word_addr_t a, input bit_addr_t b,
			input efuse_status_t exp_st);
		efuse_rsp_t r;
		do_cmd(make_cmd(op_prog, a, b), r);
		if (exp_st == st_ok) begin
			ref_mem[a][b] = 1'b1;	// One-time, OR only
		end
		check_rsp(make_rsp(exp_st, '0), r);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_base = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == err_base) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errors - err_base);
		end
	endtask

	// ******************************
	// Directed tests
	// ******************************
	task automatic blank_after_reset();
		start_test("blank_after_reset");
		read_and_check(6'd0);
		read_and_check(6'd21);
		read_and_check(6'd63);	// Top word
		end_test();
	endtask

	task automatic program_and_or();
		start_test("program_and_or");
		program_bit(6'd5, 5'd0, st_ok);
		program_bit(6'd5, 5'd7, st_ok);
		program_bit(6'd5, 5'd31, st_ok);
		program_bit(6'd5, 5'd7, st_ok);	// Already blown, stays one
		read_and_check(6'd5);
		read_and_check(6'd4);	// Neighbours untouched
		read_and_check(6'd6);
		end_test();
	endtask

	task automatic blocked_program();
		start_test("blocked_program");
		pwr_ok = 1'b0;
		program_bit(6'd9, 5'd3, st_blocked);
		pwr_ok = 1'b1;
		read_and_check(6'd9);
		end_test();
	endtask

	// Four supply flags, all good, upper bits zero
	task automatic supply_detect();
		efuse_rsp_t r;
		start_test("supply_detect");
		do_cmd(make_cmd(op_supdet, 6'd12, 5'd0), r);
		check_rsp(make_rsp(st_ok, 32'h0000_000f), r);
		end_test();
	endtask

	task automatic powered_down_refusal();
		efuse_rsp_t r;
		start_test("powered_down_refusal");
		power_down = 1'b1;
		do_cmd(make_cmd(op_read, 6'd5, 5'd0), r);
		check_rsp(make_rsp(st_powered_down, '0), r);
		program_bit(6'd5, 5'd12, st_powered_down);
		pwr_ok = 1'b0;	// Power-down wins over power-good
		program_bit(6'd5, 5'd13, st_powered_down);
		pwr_ok     = 1'b1;
		power_down = 1'b0;
		read_and_check(6'd5);
		read_and_check(6'd9);
		end_test();
	endtask

	task automatic random_programming();
		logic [31:0] v;
		word_addr_t  a;
		bit_addr_t   b;
		start_test("random_programming");
		for (int i = 0; i < 64; i++) begin
			take_bits(6, v);
			a = v[5:0];
			take_bits(5, v);
			b = v[4:0];
			program_bit(a, b, st_ok);
			if (i % 4 == 3) begin
				take_bits(6, v);
				read_and_check(v[5:0]);	// Random word
				read_and_check(a);	// Word just programmed
			end
		end
		end_test();
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		reset      = 1'b1;
		req        = 1'b0;
		cmd        = '0;
		pwr_ok     = 1'b1;
		power_down = 1'b0;
		lfsr       = 32'h516f_6d3b;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		err_base   = 0;
		for (int i = 0; i < efuse_words; i++) begin
			ref_mem[i] = '0;	// Unprogrammed part
		end
		repeat (4) @(posedge l1clk);
		#5;
		reset = 1'b0;

		blank_after_reset();
		program_and_or();
		blocked_program();
		supply_detect();
		powered_down_refusal();
		random_programming();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- testbench/efuse_props.sv
// Concurrent assertions for the sequencer
// Four-phase handshake rules and array strobe exclusion
// Bound to every efuse_ctl instance

`timescale 1ns/1ps

module efuse_props
	import efuse_pkg::*;
(
	input logic       l1clk,
	input logic       reset,
	input logic       req,
	input efuse_cmd_t cmd,
	input logic       ack,
	input logic       prog_en,
	input logic       read_en
);

	// ack only answers a pending request
	ack_rise_on_req: assert property (@(posedge l1clk) disable iff (reset)
		$rose(ack) |-> $past(req))
		else $error("ack rose with no request pending");

	// Command held by the requester for the whole request
	cmd_stable: assert property (@(posedge l1clk) disable iff (reset)
		(req && $past(req)) |-> $stable(cmd))
		else $error("cmd changed while req was high");

	strobes_exclusive: assert property (@(posedge l1clk) disable iff (reset)
		!(prog_en && read_en))
		else $error("prog_en and read_en high together");

	// Release phase, ack drops only after req is gone
	ack_fall_after_req: assert property (@(posedge l1clk) disable iff (reset)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

endmodule

bind efuse_ctl efuse_props props_inst (
	.l1clk   (l1clk),
	.reset   (reset),
	.req     (req),
	.cmd     (cmd),
	.ack     (ack),
	.prog_en (prog_en),
	.read_en (read_en)
);

//--- design/efuse_top.sv
// Controller-facing top of the efuse block
// Sequencer and fuse array with shared latency parameters

`timescale 1ns/1ps

module efuse_top
	import efuse_pkg::*;
#(
	parameter int read_lat    = 6,	// Array access time in cycles
	parameter int prog_cycles = 3	// Program pulse length
) (
	input  logic       l1clk,
	input  logic       reset,
	input  logic       req,
	input  efuse_cmd_t cmd,
	input  logic       pwr_ok,
	input  logic       power_down,
	output logic       ack,
	output efuse_rsp_t rsp
);

	// Sequencer to array
	logic                   prog_en;
	logic                   read_en;
	logic                   supdet_rd;
	word_addr_t             word_addr;
	bit_addr_t              bit_addr;
	logic                   rd_valid;
	logic [efuse_width-1:0] rd_data;

	efuse_ctl #(
		.prog_cycles (prog_cycles)
	) ctl_inst (
		.l1clk      (l1clk),
		.reset      (reset),
		.req        (req),
		.cmd        (cmd),
		.pwr_ok     (pwr_ok),
		.power_down (power_down),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.ack        (ack),
		.rsp        (rsp),
		.prog_en    (prog_en),
		.read_en    (read_en),
		.supdet_rd  (supdet_rd),
		.word_addr  (word_addr),
		.bit_addr   (bit_addr)
	);

	// Pulse length must match on both sides
	efuse_array #(
		.read_lat    (read_lat),
		.prog_cycles (prog_cycles)
	) array_inst (
		.l1clk     (l1clk),
		.reset     (reset),
		.prog_en   (prog_en),
		.read_en   (read_en),
		.supdet_rd (supdet_rd),
		.word_addr (word_addr),
		.bit_addr  (bit_addr),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

//--- design/efuse_ctl.sv
// Command sequencer for the fuse array
// Four-phase req/ack handshake towards the system controller
// Power-down and power-good checks, refusal responses
// Program pulse timing, read wait, response register

`timescale 1ns/1ps

module efuse_ctl
	import efuse_pkg::*;
#(
	parameter int prog_cycles = 3	// Program pulse length
) (
	input  logic                   l1clk,
	input  logic                   reset,
	input  logic                   req,	// Four-phase request
	input  efuse_cmd_t             cmd,	// Stable while req high
	input  logic                   pwr_ok,	// Power-good, needed for programming
	input  logic                   power_down,	// Refuse all commands
	input  logic                   rd_valid,	// From the array
	input  logic [efuse_width-1:0] rd_data,
	output logic                   ack,
	output efuse_rsp_t             rsp,	// Valid while ack high
	output logic                   prog_en,
	output logic                   read_en,
	output logic                   supdet_rd,
	output word_addr_t             word_addr,
	output bit_addr_t              bit_addr
);

	typedef enum logic [2:0] {
		s_idle,	// Waiting for req
		s_program,	// Program pulse running
		s_reading,	// Waiting on rd_valid
		s_respond,	// Pulse done, post the program result
		s_release	// ack high until req falls
	} state_t;

	localparam int pcw = $clog2(prog_cycles + 1);
	localparam logic [pcw-1:0] pcnt_last = pcw'(prog_cycles - 1);

	state_t         state;
	logic [pcw-1:0] pcnt;	// Program pulse cycle count
	logic           accept;	// New command taken this cycle
	logic           is_prog;

	assign accept  = (state == s_idle) && req;
	assign is_prog = (cmd.op == op_prog);

	// Address lines follow the accepted command
	always_ff @(posedge l1clk) begin
		if (accept) begin
			word_addr <= cmd.waddr;
			bit_addr  <= cmd.baddr;
		end
	end

	// ******************************
	// Sequencer FSM
	// ******************************
	always_ff @(posedge l1clk) begin
		if (reset) begin
			state     <= s_idle;
			ack       <= 1'b0;
			rsp       <= '0;
			prog_en   <= 1'b0;
			read_en   <= 1'b0;
			supdet_rd <= 1'b0;
			pcnt      <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (req) begin
						if (power_down) begin
							// Powered down, nothing reaches the array
							rsp   <= '{status: st_powered_down, data: '0};
							ack   <= 1'b1;
							state <= s_release;
						end else if (is_prog && !pwr_ok) begin
							rsp   <= '{status: st_blocked, data: '0};	// No VPP
							ack   <= 1'b1;
							state <= s_release;
						end else if (is_prog) begin
							prog_en <= 1'b1;	// Start the pulse
							pcnt    <= '0;
							state   <= s_program;
						end else begin
							// Word read, or supply-detect read
							read_en   <= 1'b1;
							supdet_rd <= (cmd.op == op_supdet);
							state     <= s_reading;
						end
					end
				end
				s_program: begin
					if (pcnt == pcnt_last) begin
						prog_en <= 1'b0;	// Last pulse cycle
						state   <= s_respond;
					end else begin
						pcnt <= pcnt + 1'b1;
					end
				end
				s_reading: begin
					if (rd_valid) begin
						read_en   <= 1'b0;
						supdet_rd <= 1'b0;
						rsp       <= '{status: st_ok, data: rd_data};
						ack       <= 1'b1;
						state     <= s_release;
					end
				end
				s_respond: begin
					rsp   <= '{status: st_ok, data: '0};	// Program has no data
					ack   <= 1'b1;
					state <= s_release;
				end
				s_release: begin
					// Hold ack and rsp until the requester lets go
					if (!req) begin
						ack   <= 1'b0;
						state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

//--- design/efuse_array.sv
// Fuse array model
// 64 x 32 one-time programmable storage
// Program pulse counter, bit set on the last pulse cycle
// Read latency counter, word read and supply-detect read

`timescale 1ns/1ps

module efuse_array
	import efuse_pkg::*;
#(
	parameter int read_lat    = 6,	// Cycles from read_en rise to rd_valid
	parameter int prog_cycles = 3	// Program pulse length
) (
	input  logic                   l1clk,
	input  logic                   reset,
	input  logic                   prog_en,	// Program pulse
	input  logic                   read_en,	// Held until rd_valid
	input  logic                   supdet_rd,	// Read supply flags, not a word
	input  word_addr_t             word_addr,
	input  bit_addr_t              bit_addr,
	output logic                   rd_valid,
	output logic [efuse_width-1:0] rd_data	// Zero while rd_valid low
);

	// Counter widths hold 0 .. N-1 for N of 1 or more
	localparam int pcw = $clog2(prog_cycles + 1);
	localparam int rcw = $clog2(read_lat + 1);
	localparam logic [pcw-1:0] pcnt_last = pcw'(prog_cycles - 1);
	localparam logic [rcw-1:0] rcnt_last = rcw'(read_lat - 1);

	logic [efuse_width-1:0] fuse_mem [efuse_words];	// Fuse words
	logic [pcw-1:0]         pcnt;	// Cycles of prog_en seen so far
	logic [rcw-1:0]         rcnt;	// Cycles of read_en seen so far
	logic [efuse_width-1:0] supdet_word;
	logic [efuse_width-1:0] read_word;

	// Supply flags sit in the low bits, upper bits read zero
	assign supdet_word = {{(efuse_width - $bits(supdet_ok)){1'b0}}, supdet_ok};
	assign read_word   = supdet_rd ? supdet_word : fuse_mem[word_addr];

	// ******************************
	// Programming
	// ******************************
	// Reset clears every fuse word
	always_ff @(posedge l1clk) begin
		if (reset) begin
			pcnt <= '0;
			for (int i = 0; i < efuse_words; i++) begin
				fuse_mem[i] <= '0;
			end
		end else if (!prog_en) begin
			pcnt <= '0;	// Pulse dropped early, nothing blown
		end else if (pcnt == pcnt_last) begin
			// Full pulse seen, blow the fuse
			fuse_mem[word_addr][bit_addr] <= 1'b1;	// OR in, never clear
		end else begin
			pcnt <= pcnt + 1'b1;
		end
	end

	// ******************************
	// Read path
	// ******************************
	// rd_valid on the read_lat-th cycle that read_en is sampled high
	always_ff @(posedge l1clk) begin
		if (reset) begin
			rcnt     <= '0;
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else if (!read_en) begin
			// Read over, output returns to zero
			rcnt     <= '0;
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else if (!rd_valid) begin
			if (rcnt == rcnt_last) begin
				rd_valid <= 1'b1;
				rd_data  <= read_word;	// Captured once per read
			end else begin
				rcnt <= rcnt + 1'b1;	// Access time still running
			end
		end
		// Data holds while read_en stays high
	end

endmodule

//--- design/efuse_pkg.sv
// Shared types for the efuse block
// Array geometry, index types
// Opcode and status enums
// Command and response structs
// Supply-detect result constant

package efuse_pkg;

	// ******************************
	// Array geometry
	// ******************************
	localparam int efuse_words = 64;	// Words in the fuse array
	localparam int efuse_width = 32;	// Bits per fuse word

	typedef logic [$clog2(efuse_words)-1:0] word_addr_t;	// 6-bit word index
	typedef logic [$clog2(efuse_width)-1:0] bit_addr_t;	// 5-bit bit index

	// ******************************
	// Command and result codes
	// ******************************
	typedef enum logic [1:0] {
		op_read   = 2'd0,	// Word read
		op_prog   = 2'd1,	// Program a single bit
		op_supdet = 2'd2	// Supply-detect read
	} efuse_op_t;

	typedef enum logic [1:0] {
		st_ok           = 2'd0,
		st_blocked      = 2'd1,	// Program tried with power-good low
		st_powered_down = 2'd2	// Block is powered down
	} efuse_status_t;

	// Request from the system controller, 13 bits
	typedef struct packed {
		efuse_op_t  op;
		word_addr_t waddr;
		bit_addr_t  baddr;	// Only used by op_prog
	} efuse_cmd_t;

	// Answer to the system controller, 34 bits
	typedef struct packed {
		efuse_status_t           status;
		logic [efuse_width-1:0] data;	// Zero on refusal and program
	} efuse_rsp_t;

	// Level, vddc, vddo and vpp detectors, all good in the model
	localparam logic [3:0] supdet_ok = 4'b1111;

endpackage
